//--- verilog/uart_pkg.sv
// UART link shared definitions
`default_nettype none

package uart_pkg;

	// fixed frame format
	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 2;
	localparam int CLKS_PER_BIT = 10;

	// start + data + parity + stop
	localparam int FRAME_BITS = 1 + DATA_BITS + 1 + STOP_BITS;

	// buffering and host credits
	localparam int TX_FIFO_DEPTH = 4;
	localparam int RX_FIFO_DEPTH = 4;
	localparam int HOST_RX_CREDITS = 2;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;
	} tx_word_t;

	typedef struct packed {
		logic [DATA_BITS-1:0] data;
		logic                 parity_err;
		logic                 frame_err;
	} rx_word_t;

	// labels carry a prefix so both enums can live in one package
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_t;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

	// even parity bit: set when the byte holds an odd number of ones
	function automatic logic even_parity(input logic [DATA_BITS-1:0] bits);
		return ^bits;
	endfunction

endpackage

`default_nettype wire

//--- verilog/baud_timer.sv
// Bit period timer
`timescale 1ns/1ns
`default_nettype none

module baud_timer (
	input  logic clk,
	input  logic rst,
	input  logic restart,
	input  logic half,
	output logic tick
);

	localparam int CNT_W = $clog2(uart_pkg::CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] FULL_LOAD = CNT_W'(uart_pkg::CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_LOAD = CNT_W'(uart_pkg::CLKS_PER_BIT / 2 - 1);

	logic [CNT_W-1:0] cnt;

	// counts down, tick on zero
	assign tick = (cnt == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= FULL_LOAD;
		end else if (restart) begin
			// restart takes priority over the running count
			cnt <= half ? HALF_LOAD : FULL_LOAD;
		end else if (tick) begin
			cnt <= FULL_LOAD;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/credit_fifo.sv
// Credit flow FIFO
`timescale 1ns/1ns
`default_nettype none

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t push_data,
	output logic     full,
	input  logic     pop,
	output logic     pop_valid,
	output payload_t pop_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(DEPTH);

	payload_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	logic do_push;
	logic do_pop;

	assign full      = (count == DEPTH_CNT);
	assign pop_valid = (count != '0);
	assign pop_data  = mem[rd_ptr];

	// a push into a full buffer is ignored
	assign do_push = push && !full;
	assign do_pop  = pop && pop_valid;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			// occupancy
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_tx_fsm.sv
// UART transmit state machine
`timescale 1ns/1ns
`default_nettype none

module uart_tx_fsm (
	input  logic               clk,
	input  logic               rst,
	input  logic               word_valid,
	input  uart_pkg::tx_word_t word,
	output logic               take,
	output logic               tx
);

	localparam int BIT_W  = $clog2(uart_pkg::DATA_BITS);
	localparam int STOP_W = $clog2(uart_pkg::STOP_BITS + 1);
	localparam logic [BIT_W-1:0]  LAST_BIT   = BIT_W'(uart_pkg::DATA_BITS - 1);
	localparam logic [STOP_W-1:0] STOP_START = STOP_W'(uart_pkg::STOP_BITS - 1);

	uart_pkg::tx_state_t state;

	logic [uart_pkg::DATA_BITS-1:0] shift;
	logic                           parity;
	logic [BIT_W-1:0]               bit_cnt;
	logic [STOP_W-1:0]              stop_cnt;
	logic                           tick;
	logic                           last_stop;

	// end of the final stop bit
	assign last_stop = (state == uart_pkg::TX_STOP) && tick && (stop_cnt == '0);

	// next word is taken when idle or right at the end of a frame
	assign take = word_valid && ((state == uart_pkg::TX_IDLE) || last_stop);

	baud_timer baud_timer_inst (
		.clk     (clk),
		.rst     (rst),
		.restart (take),
		.half    (1'b0),
		.tick    (tick)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= uart_pkg::TX_IDLE;
			tx       <= 1'b1;
			bit_cnt  <= '0;
			stop_cnt <= '0;
		end else if (take) begin
			// latch word and drive the start bit
			state   <= uart_pkg::TX_START;
			tx      <= 1'b0;
			bit_cnt <= '0;
		end else begin
			case (state)
				uart_pkg::TX_IDLE: begin
					tx <= 1'b1;
				end
				uart_pkg::TX_START: begin
					if (tick) begin
						tx    <= shift[0];
						state <= uart_pkg::TX_DATA;
					end
				end
				uart_pkg::TX_DATA: begin
					if (tick) begin
						if (bit_cnt == LAST_BIT) begin
							tx    <= parity;
							state <= uart_pkg::TX_PARITY;
						end else begin
							tx      <= shift[0];
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				uart_pkg::TX_PARITY: begin
					if (tick) begin
						tx       <= 1'b1;
						stop_cnt <= STOP_START;
						state    <= uart_pkg::TX_STOP;
					end
				end
				uart_pkg::TX_STOP: begin
					if (last_stop) begin
						state <= uart_pkg::TX_IDLE;
					end else if (tick) begin
						stop_cnt <= stop_cnt - 1'b1;
					end
				end
				default: state <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// payload path, LSB goes out first
	always_ff @(posedge clk) begin
		if (take) begin
			shift  <= word.data;
			parity <= uart_pkg::even_parity(word.data);
		end else if (tick && (state == uart_pkg::TX_START || state == uart_pkg::TX_DATA)) begin
			shift <= shift >> 1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_rx_fsm.sv
// UART receive state machine
`timescale 1ns/1ns
`default_nettype none

module uart_rx_fsm (
	input  logic               clk,
	input  logic               rst,
	input  logic               rx,
	input  logic               fifo_full,
	output logic               push,
	output uart_pkg::rx_word_t push_word,
	output logic               overrun
);

	localparam int BIT_W  = $clog2(uart_pkg::DATA_BITS);
	localparam int STOP_W = $clog2(uart_pkg::STOP_BITS + 1);
	localparam logic [BIT_W-1:0]  LAST_BIT   = BIT_W'(uart_pkg::DATA_BITS - 1);
	localparam logic [STOP_W-1:0] STOP_START = STOP_W'(uart_pkg::STOP_BITS - 1);

	uart_pkg::rx_state_t state;

	logic                           rx_meta;
	logic                           rx_sync;
	logic                           rx_prev;
	logic                           fall;
	logic                           tick;
	logic [uart_pkg::DATA_BITS-1:0] shift;
	logic [BIT_W-1:0]               bit_cnt;
	logic [STOP_W-1:0]              stop_cnt;
	logic                           par_err;
	logic                           stop_err;

	// two flop synchronizer plus one more flop for the edge
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign fall = rx_prev && !rx_sync;

	// half period first, so later ticks land mid-bit
	baud_timer baud_timer_inst (
		.clk     (clk),
		.rst     (rst),
		.restart ((state == uart_pkg::RX_IDLE) && fall),
		.half    (1'b1),
		.tick    (tick)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= uart_pkg::RX_IDLE;
			bit_cnt  <= '0;
			stop_cnt <= '0;
			push     <= 1'b0;
			overrun  <= 1'b0;
		end else begin
			push <= 1'b0;
			case (state)
				uart_pkg::RX_IDLE: begin
					if (fall) begin
						state <= uart_pkg::RX_START;
					end
				end
				uart_pkg::RX_START: begin
					// glitch shorter than half a bit goes back to idle
					if (tick) begin
						bit_cnt <= '0;
						state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
					end
				end
				uart_pkg::RX_DATA: begin
					if (tick) begin
						if (bit_cnt == LAST_BIT) begin
							state <= uart_pkg::RX_PARITY;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
				end
				uart_pkg::RX_PARITY: begin
					if (tick) begin
						stop_cnt <= STOP_START;
						state    <= uart_pkg::RX_STOP;
					end
				end
				uart_pkg::RX_STOP: begin
					if (tick) begin
						if (stop_cnt == '0) begin
							// frame done, push next cycle or drop it
							state <= uart_pkg::RX_IDLE;
							if (fifo_full) begin
								overrun <= 1'b1;
							end else begin
								push <= 1'b1;
							end
						end else begin
							stop_cnt <= stop_cnt - 1'b1;
						end
					end
				end
				default: state <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	// data and error flags
	always_ff @(posedge clk) begin
		if (tick) begin
			case (state)
				uart_pkg::RX_DATA: shift <= {rx_sync, shift[uart_pkg::DATA_BITS-1:1]};
				uart_pkg::RX_PARITY: begin
					par_err  <= (rx_sync != uart_pkg::even_parity(shift));
					stop_err <= 1'b0;
				end
				uart_pkg::RX_STOP: begin
					if (stop_cnt == '0) begin
						push_word.data       <= shift;
						push_word.parity_err <= par_err;
						push_word.frame_err  <= stop_err || !rx_sync;
					end else if (!rx_sync) begin
						stop_err <= 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/uart_link_top.sv
// UART link top level
`timescale 1ns/1ns
`default_nettype none

module uart_link_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               tx_valid,
	input  uart_pkg::tx_word_t tx_word,
	output logic               tx_credit,
	output logic               rx_valid,
	output uart_pkg::rx_word_t rx_word,
	input  logic               rx_credit,
	output logic               rx_overrun,
	output logic               tx,
	input  logic               rx
);

	localparam int CRED_W = $clog2(uart_pkg::HOST_RX_CREDITS + 1);
	localparam logic [CRED_W-1:0] CRED_INIT = CRED_W'(uart_pkg::HOST_RX_CREDITS);

	uart_pkg::tx_word_t tx_pop_data;
	uart_pkg::rx_word_t rx_push_word;
	uart_pkg::rx_word_t rx_pop_data;

	logic              tx_pop_valid;
	logic              tx_pop;
	logic              rx_push;
	logic              rx_full;
	logic              rx_pop_valid;
	logic              rx_pop;
	logic [CRED_W-1:0] rx_credits;

	// one credit back to the host per word handed to the serializer
	assign tx_credit = tx_pop;

	credit_fifo #(
		.payload_t (uart_pkg::tx_word_t),
		.DEPTH     (uart_pkg::TX_FIFO_DEPTH)
	) tx_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.push      (tx_valid),
		.push_data (tx_word),
		.full      (),
		.pop       (tx_pop),
		.pop_valid (tx_pop_valid),
		.pop_data  (tx_pop_data)
	);

	uart_tx_fsm uart_tx_fsm_inst (
		.clk        (clk),
		.rst        (rst),
		.word_valid (tx_pop_valid),
		.word       (tx_pop_data),
		.take       (tx_pop),
		.tx         (tx)
	);

	uart_rx_fsm uart_rx_fsm_inst (
		.clk       (clk),
		.rst       (rst),
		.rx        (rx),
		.fifo_full (rx_full),
		.push      (rx_push),
		.push_word (rx_push_word),
		.overrun   (rx_overrun)
	);

	credit_fifo #(
		.payload_t (uart_pkg::rx_word_t),
		.DEPTH     (uart_pkg::RX_FIFO_DEPTH)
	) rx_fifo_inst (
		.clk       (clk),
		.rst       (rst),
		.push      (rx_push),
		.push_data (rx_push_word),
		.full      (rx_full),
		.pop       (rx_pop),
		.pop_valid (rx_pop_valid),
		.pop_data  (rx_pop_data)
	);

	// deliver only while the host has room
	assign rx_pop = rx_pop_valid && (rx_credits != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_valid   <= 1'b0;
			rx_credits <= CRED_INIT;
		end else begin
			rx_valid <= rx_pop;
			case ({rx_pop, rx_credit})
				2'b10:   rx_credits <= rx_credits - 1'b1;
				2'b01:   rx_credits <= rx_credits + 1'b1;
				default: rx_credits <= rx_credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_pop) begin
			rx_word <= rx_pop_data;
		end
	end

endmodule

`default_nettype wire

//--- tb/uart_link_tb.sv
// UART link testbench
`timescale 1ns/1ns
`default_nettype none

module uart_link_tb;

	localparam int FRAME_CYCLES = uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;
	localparam int DB = uart_pkg::DATA_BITS;

	logic               clk = 1'b0;
	logic               rst;
	logic               tx_valid;
	uart_pkg::tx_word_t tx_word;
	logic               tx_credit;
	logic               rx_valid;
	uart_pkg::rx_word_t rx_word;
	logic               rx_credit;
	logic               rx_overrun;
	logic               tx;
	logic               rx;

	// serial line, looped back or driven here
	logic loop_sel;
	logic rx_drv;

	// host bookkeeping
	int                 tx_credits;
	int                 credit_pulses;
	int                 rx_held;
	logic               stall;
	logic [DB-1:0]      tx_exp[$];
	uart_pkg::rx_word_t rx_got[$];

	// tx line monitor
	logic tx_seen_high = 1'b0;
	logic tx_follow;
	int   tx_idle_run;
	int   frames_done;

	int    seed;
	int    checks;
	int    errors;
	string cur_test;

	assign rx = loop_sel ? tx : rx_drv;

	always #4 clk = ~clk;

	uart_link_top uart_link_top_inst (
		.clk        (clk),
		.rst        (rst),
		.tx_valid   (tx_valid),
		.tx_word    (tx_word),
		.tx_credit  (tx_credit),
		.rx_valid   (rx_valid),
		.rx_word    (rx_word),
		.rx_credit  (rx_credit),
		.rx_overrun (rx_overrun),
		.tx         (tx),
		.rx         (rx)
	);

	task automatic check_value(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error %s %s: expected %0h actual %0h", cur_test, field, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("timeout in %s while %s", cur_test, what);
		$display("checks %0d, errors %0d", checks, errors);
		$display("FAIL: see errors above");
		$finish;
	endtask

	// even parity bit from a count of the ones in the byte
	function automatic logic odd_ones(input logic [DB-1:0] b);
		int n;
		n = 0;
		for (int j = 0; j < DB; j++) begin
			if (b[j]) begin
				n++;
			end
		end
		return (n % 2) == 1;
	endfunction

	task automatic apply_reset;
		@(negedge clk);
		rst = 1'b1;
		tx_valid = 1'b0;
		loop_sel = 1'b0;
		rx_drv = 1'b1;
		stall = 1'b0;
		repeat (10) @(negedge clk);
		tx_credits = uart_pkg::TX_FIFO_DEPTH;
		tx_exp.delete();
		rx_got.delete();
		rst = 1'b0;
		check_value("reset_tx", 1, tx);
		check_value("reset_tx_credit", 0, tx_credit);
		check_value("reset_rx_valid", 0, rx_valid);
		check_value("reset_rx_overrun", 0, rx_overrun);
	endtask

	// one word per call, spends a credit
	task automatic send_byte(input logic [DB-1:0] b);
		int waited;
		waited = 0;
		while (tx_credits == 0 && waited < 2 * FRAME_CYCLES) begin
			tx_valid = 1'b0;
			@(negedge clk);
			waited++;
		end
		if (tx_credits == 0) begin
			report_timeout("waiting for a transmit credit");
		end
		tx_valid = 1'b1;
		tx_word.data = b;
		tx_credits--;
		tx_exp.push_back(b);
		@(negedge clk);
	endtask

	task automatic wait_rx_count(input int n, input int frames);
		int waited;
		waited = 0;
		while (rx_got.size() < n && waited < (frames + 2) * FRAME_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (rx_got.size() < n) begin
			report_timeout("waiting for received words");
		end
	endtask

	task automatic wait_frames(input int n);
		int waited;
		waited = 0;
		while (frames_done < n && waited < (n + 2) * FRAME_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (frames_done < n) begin
			report_timeout("waiting for frames on tx");
		end
	endtask

	task automatic wait_credits_home;
		int waited;
		waited = 0;
		while (tx_credits != uart_pkg::TX_FIFO_DEPTH && waited < FRAME_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		if (tx_credits != uart_pkg::TX_FIFO_DEPTH) begin
			report_timeout("waiting for transmit credits to return");
		end
	endtask

	// mid-bit samples from the start edge, offset 0 is the first falling clock
	task automatic watch_frame;
		logic [DB-1:0] b;
		logic          exp_bit;
		int            i;
		int            k;
		if (tx_exp.size() == 0) begin
			errors++;
			$display("start bit on tx in %s with no byte queued", cur_test);
			return;
		end
		b = tx_exp.pop_front();
		if (tx_follow) begin
			check_value("tx_gap", 0, tx_idle_run);
		end
		for (i = 0; i < FRAME_CYCLES; i++) begin
			if (i > 0) begin
				@(negedge clk);
			end
			if (i % uart_pkg::CLKS_PER_BIT == uart_pkg::CLKS_PER_BIT / 2) begin
				k = i / uart_pkg::CLKS_PER_BIT;
				if (k == 0) begin
					exp_bit = 1'b0;
				end else if (k <= DB) begin
					exp_bit = b[k-1];
				end else if (k == DB + 1) begin
					exp_bit = odd_ones(b);
				end else begin
					exp_bit = 1'b1;
				end
				check_value($sformatf("tx_bit%0d", k), exp_bit, tx);
			end
		end
		// last cycle of the final stop bit
		check_value("tx_frame_end", 1, tx);
		tx_follow = (tx_exp.size() != 0);
		tx_idle_run = 0;
		frames_done++;
	endtask

	always begin
		@(negedge clk);
		if (rst) begin
			tx_follow = 1'b0;
			tx_idle_run = 0;
		end else if (tx_seen_high && tx === 1'b0) begin
			watch_frame();
		end else begin
			tx_idle_run++;
		end
		tx_seen_high = (tx === 1'b1);
	end

	// transmit credits coming back
	always @(negedge clk) begin
		if (!rst && tx_credit === 1'b1) begin
			tx_credits++;
			credit_pulses++;
			if (tx_credits > uart_pkg::TX_FIFO_DEPTH) begin
				errors++;
				$display("more transmit credits returned than words sent in %s", cur_test);
			end
		end
	end

	// host receive buffer, one credit back per cycle unless stalled
	always @(negedge clk) begin
		if (rst) begin
			rx_held = 0;
			rx_credit = 1'b0;
		end else begin
			if (rx_valid === 1'b1) begin
				rx_got.push_back(rx_word);
				rx_held++;
				if (rx_held > uart_pkg::HOST_RX_CREDITS) begin
					errors++;
					$display("rx_valid delivered a word with no host credit in %s", cur_test);
				end
			end
			if (!stall && rx_held > 0) begin
				rx_credit = 1'b1;
				rx_held--;
			end else begin
				rx_credit = 1'b0;
			end
		end
	end

	task automatic run_loopback(input logic [DB-1:0] first, input int count, input logic hold);
		logic [DB-1:0] sent[$];
		logic [DB-1:0] b;
		int            kept;
		int            i;
		kept = hold ? uart_pkg::HOST_RX_CREDITS + uart_pkg::RX_FIFO_DEPTH : count;
		credit_pulses = 0;
		frames_done = 0;
		loop_sel = 1'b1;
		stall = hold;
		rx_got.delete();
		for (i = 0; i < count; i++) begin
			b = (i == 0) ? first : DB'($random(seed));
			sent.push_back(b);
			send_byte(b);
		end
		tx_valid = 1'b0;
		if (hold) begin
			wait_frames(count);
			// receiver still finishing the last stop bit
			repeat (2 * uart_pkg::CLKS_PER_BIT) @(negedge clk);
			check_value("rx_held_words", uart_pkg::HOST_RX_CREDITS, rx_got.size());
			check_value("rx_overrun", 1, rx_overrun);
			stall = 1'b0;
		end
		wait_rx_count(kept, count);
		wait_frames(count);
		wait_credits_home();
		repeat (2 * uart_pkg::CLKS_PER_BIT) @(negedge clk);
		check_value("rx_words", kept, rx_got.size());
		check_value("rx_overrun_end", hold, rx_overrun);
		check_value("tx_credit_pulses", count, credit_pulses);
		for (i = 0; i < kept && i < rx_got.size(); i++) begin
			check_value($sformatf("rx_data%0d", i), sent[i], rx_got[i].data);
			check_value($sformatf("parity_err%0d", i), 0, rx_got[i].parity_err);
			check_value($sformatf("frame_err%0d", i), 0, rx_got[i].frame_err);
		end
	endtask

	task automatic run_inject(input logic [DB-1:0] b, input string fault);
		logic [uart_pkg::FRAME_BITS-1:0] frame;
		int                              i;
		loop_sel = 1'b0;
		stall = 1'b0;
		rx_got.delete();
		// index 0 goes out first
		frame = '1;
		frame[0] = 1'b0;
		frame[DB:1] = b;
		frame[DB+1] = odd_ones(b) ^ (fault == "parity");
		if (fault == "stop") begin
			frame[DB+2] = 1'b0;
		end
		for (i = 0; i < uart_pkg::FRAME_BITS; i++) begin
			rx_drv = frame[i];
			repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
		end
		rx_drv = 1'b1;
		wait_rx_count(1, 1);
		check_value("rx_data", b, rx_got[0].data);
		check_value("parity_err", fault == "parity", rx_got[0].parity_err);
		check_value("frame_err", fault == "stop", rx_got[0].frame_err);
	endtask

	task automatic run_case(input string name, input string mode, input logic [DB-1:0] value,
			input string fault);
		cur_test = name;
		if (mode == "loop") begin
			run_loopback(value, uart_pkg::TX_FIFO_DEPTH, 1'b0);
		end else if (mode == "inject") begin
			run_inject(value, fault);
		end else if (mode == "stall") begin
			apply_reset();
			// two frames beyond host credits plus FIFO depth, so two get dropped
			run_loopback(value, uart_pkg::HOST_RX_CREDITS + uart_pkg::RX_FIFO_DEPTH + 2, 1'b1);
			apply_reset();
		end else begin
			errors++;
			$display("unknown mode %s in case %s", mode, name);
		end
	endtask

	initial begin
		int            fd;
		int            fields;
		string         line;
		string         name;
		string         mode;
		string         fault;
		logic [DB-1:0] value;
		seed = 53480;
		checks = 0;
		errors = 0;
		rst = 1'b1;
		tx_valid = 1'b0;
		tx_word = '0;
		rx_credit = 1'b0;
		loop_sel = 1'b0;
		rx_drv = 1'b1;
		stall = 1'b0;
		frames_done = 0;
		cur_test = "reset";
		apply_reset();
		fd = $fopen("tb/uart_link_cases.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the case file");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line.getc(0) != "#") begin
					fields = $sscanf(line, "%s %s %h %s", name, mode, value, fault);
					if (fields != 4) begin
						errors++;
						$display("malformed case line: %s", line);
					end else begin
						run_case(name, mode, value, fault);
					end
				end
			end
			$fclose(fd);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/uart_link_cases.txt
# columns: test name, mode (loop inject stall), byte in hex, fault (none parity stop)
# loop cases send the byte then random background bytes back-to-back
loop_a5 loop a5 none
loop_zero loop 00 none
loop_ones loop ff none
loop_lsb loop 01 none
loop_msb loop 80 none
loop_3c loop 3c none
inject_clean inject 5a none
inject_parity_96 inject 96 parity
inject_parity_00 inject 00 parity
inject_parity_7f inject 7f parity
inject_stop_c3 inject c3 stop
inject_stop_ff inject ff stop
inject_stop_00 inject 00 stop
stall_burst stall 42 none
loop_after_stall loop e7 none
inject_after_stall inject 81 none

//--- verilog.f
verilog/uart_pkg.sv
verilog/baud_timer.sv
verilog/credit_fifo.sv
verilog/uart_tx_fsm.sv
verilog/uart_rx_fsm.sv
verilog/uart_link_top.sv
tb/uart_link_tb.sv

//--- Makefile
# Verilator build and run for the UART link

TOP := uart_link_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f verilog.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
